// File: Bender.yml
package:
  name: board_io_harness

sources:
  - include_dirs:
      - common
    files:
      - common/io_harness_pkg.sv
      - common/io_port_if.sv
      - port_bank/io_port_bank.sv
      - hdl/io_cmd_router.sv
      - hdl/board_io_harness.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/board_io_harness_assert.sv
      - test/board_io_harness_tb.sv

// File: common/io_harness_cfg.svh
`ifndef IO_HARNESS_CFG_SVH
`define IO_HARNESS_CFG_SVH

// Bank geometry
`define IO_LANES    4                       // Lanes per bank
`define IO_WORD_W   8                       // Bits per lane
`define IO_BUS_W    (`IO_LANES * `IO_WORD_W) // Flattened lane bus, also serial depth

// Command stream
`define IO_CMD_W    16                      // Command word width

// Command field encodings
`define IO_OP_WR    1'b1                    // op bit for a write
`define IO_OP_RD    1'b0                    // op bit for a read
`define IO_PORT_A   1'b0                    // Bank A select
`define IO_PORT_B   1'b1                    // Bank B select

// Board overlay on bank A
`define IO_DIP_LANE 0                       // Lane read back as the switches
`define IO_BTN_LANE 1                       // Lane whose low bits are the buttons
`define IO_BTN_W    2                       // Number of push buttons

// LED register source
`define IO_LED_LANE 0                       // Bank B lane mirrored on the LEDs

`endif

// File: common/io_harness_pkg.sv
`include "io_harness_cfg.svh"

package io_harness_pkg;

    // Lane number within one bank
    typedef logic [$clog2(`IO_LANES)-1:0] lane_idx_t;

    // Write view, op = 1
    typedef struct packed {
        logic                  op;      // 1 for a write
        logic                  port;    // 0 selects A, 1 selects B
        lane_idx_t             lane;    // Target output lane
        logic [3:0]            spare;   // Ignored
        logic [`IO_WORD_W-1:0] wdata;   // New lane value
    } io_cmd_wr_t;

    // Read view, op = 0
    typedef struct packed {
        logic                  op;      // 0 for a read
        logic                  port;    // Bank select
        lane_idx_t             lane;    // Input lane to sample
        logic                  invert;  // Complement after masking
        logic [2:0]            spare;   // Ignored
        logic [`IO_WORD_W-1:0] mask;    // AND mask on the input word
    } io_cmd_rd_t;

    // One command word, two decodes. op, port and lane sit in the same
    // place in both views, so either view can be used to pick the path
    typedef union packed {
        io_cmd_wr_t wr;
        io_cmd_rd_t rd;
    } io_cmd_t;

endpackage

// File: common/io_port_if.sv
`include "io_harness_cfg.svh"

interface io_port_if;
    import io_harness_pkg::*;

    // Router to bank
    logic                  we;        // One-cycle write strobe
    lane_idx_t             lane;      // Addressed lane, shared by read and write
    logic [`IO_WORD_W-1:0] wdata;     // Write data

    // Bank to router
    logic [`IO_WORD_W-1:0] rdata;     // Input lane at lane, combinational
    logic [`IO_WORD_W-1:0] odata;     // Output register at lane, pre-write value
    logic [`IO_BUS_W-1:0]  out_bus;   // All output lanes, lane 0 in the low byte
    logic [`IO_LANES-1:0]  wren_bus;  // Registered per-lane write strobes

    modport router (
        output we, lane, wdata,
        input  rdata, odata, out_bus, wren_bus
    );

    modport bank (
        input  we, lane, wdata,
        output rdata, odata, out_bus, wren_bus
    );

endinterface

// File: hdl/board_io_harness.sv
`include "io_harness_cfg.svh"

module board_io_harness (
    input  logic                 clock,
    input  logic                 arst_n,

    // Command stream in place of the CPU
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  logic [`IO_CMD_W-1:0] cmd_word,

    // Responses
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output logic [7:0]           rsp_data,

    // Board switches and buttons
    input  logic [7:0]           dip_switch,
    input  logic [1:0]           push_button,

    // Serial pins and reduced outputs per bank
    input  logic                 a_serial_in,
    input  logic                 b_serial_in,
    output logic                 a_wren_pin,
    output logic                 a_out_pin,
    output logic                 b_wren_pin,
    output logic                 b_out_pin,
    output logic [7:0]           led
);

    io_port_if port_a_if ();     // Router to bank A
    io_port_if port_b_if ();     // Router to bank B

    io_port_bank bank_a (
        .clock     (clock),
        .arst_n    (arst_n),
        .serial_in (a_serial_in),
        .bus       (port_a_if)
    );

    io_port_bank bank_b (
        .clock     (clock),
        .arst_n    (arst_n),
        .serial_in (b_serial_in),
        .bus       (port_b_if)
    );

    io_cmd_router router (
        .clock       (clock),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_word    (cmd_word),   // Raw word, decoded as a union inside
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_data    (rsp_data),
        .dip_switch  (dip_switch),
        .push_button (push_button),
        .port_a      (port_a_if),
        .port_b      (port_b_if),
        .a_wren_pin  (a_wren_pin),
        .a_out_pin   (a_out_pin),
        .b_wren_pin  (b_wren_pin),
        .b_out_pin   (b_out_pin),
        .led         (led)
    );

endmodule

// File: hdl/io_cmd_router.sv
`include "io_harness_cfg.svh"

module io_cmd_router (
    input  logic                    clock,
    input  logic                    arst_n,

    // Command stream
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  io_harness_pkg::io_cmd_t cmd_word,

    // Response stream
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [7:0]              rsp_data,

    // Board inputs overlaid on bank A
    input  logic [7:0]              dip_switch,
    input  logic [1:0]              push_button,

    // Bank links
    io_port_if.router               port_a,
    io_port_if.router               port_b,

    // Reduced board outputs
    output logic                    a_wren_pin,
    output logic                    a_out_pin,
    output logic                    b_wren_pin,
    output logic                    b_out_pin,
    output logic [7:0]              led
);

    import io_harness_pkg::*;

    localparam int WORD_W = `IO_WORD_W;

    logic              run_q;         // Low until the first edge after reset
    logic              accept;        // Command transfers this cycle
    logic              is_wr;         // Decoded op
    logic              to_b;          // Decoded bank
    lane_idx_t         sel_lane;      // Decoded lane
    logic [WORD_W-1:0] sel_rdata;     // Input word from the addressed bank
    logic [WORD_W-1:0] sel_odata;     // Pre-write output word
    logic [WORD_W-1:0] in_word;       // Input word after the board overlay
    logic [WORD_W-1:0] masked_word;
    logic [WORD_W-1:0] rd_result;
    logic [WORD_W-1:0] rsp_next;      // Value for the response buffer

    // Handshake
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Buffer free, or draining this cycle
    assign cmd_ready = run_q && (!rsp_valid || rsp_ready);
    assign accept    = cmd_valid && cmd_ready;

    // Decode, op/port/lane share positions in both views
    assign is_wr    = (cmd_word.wr.op == `IO_OP_WR);
    assign to_b     = (cmd_word.wr.port == `IO_PORT_B);
    assign sel_lane = cmd_word.wr.lane;

    // Both banks see lane and data, only the addressed one gets we
    assign port_a.lane  = sel_lane;
    assign port_b.lane  = sel_lane;
    assign port_a.wdata = cmd_word.wr.wdata;
    assign port_b.wdata = cmd_word.wr.wdata;
    assign port_a.we    = accept && is_wr && !to_b;
    assign port_b.we    = accept && is_wr && to_b;

    assign sel_rdata = to_b ? port_b.rdata : port_a.rdata;
    assign sel_odata = to_b ? port_b.odata : port_a.odata;

    // Switches and buttons replace bank A's low input bits
    always_comb begin
        in_word = sel_rdata;
        if (!to_b) begin
            if (sel_lane == lane_idx_t'(`IO_DIP_LANE)) begin
                in_word = dip_switch;
            end else if (sel_lane == lane_idx_t'(`IO_BTN_LANE)) begin
                in_word[`IO_BTN_W-1:0] = push_button;
            end
        end
    end

    assign masked_word = in_word & cmd_word.rd.mask;
    assign rd_result   = cmd_word.rd.invert ? ~masked_word : masked_word;
    assign rsp_next    = is_wr ? sel_odata : rd_result;   // Write returns old value

    // One-entry response buffer
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;                            // Drained, nothing new
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rsp_data <= rsp_next;                         // Held until the next accept
        end
    end

    // Pin reducers, one cycle behind the bank buses
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            a_wren_pin <= 1'b0;
            a_out_pin  <= 1'b0;
            b_wren_pin <= 1'b0;
            b_out_pin  <= 1'b0;
        end else begin
            a_wren_pin <= |port_a.wren_bus;
            a_out_pin  <= ^port_a.out_bus;
            b_wren_pin <= |port_b.wren_bus;
            b_out_pin  <= ^port_b.out_bus;
        end
    end

    // LEDs track bank B lane 0 on its strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else if (port_b.wren_bus[`IO_LED_LANE]) begin
            led <= port_b.out_bus[`IO_LED_LANE*WORD_W +: WORD_W];
        end
    end

endmodule

// File: port_bank/io_port_bank.sv
`include "io_harness_cfg.svh"

module io_port_bank (
    input  logic    clock,
    input  logic    arst_n,
    input  logic    serial_in,   // Board pin feeding the input lanes
    io_port_if.bank bus
);

    localparam int LANES  = `IO_LANES;
    localparam int WORD_W = `IO_WORD_W;
    localparam int BUS_W  = `IO_BUS_W;

    logic [BUS_W-1:0]  shift_q;           // Serial deserializer, newest bit at 0
    logic [WORD_W-1:0] out_q [LANES];     // Output lane registers
    logic [LANES-1:0]  wren_q;            // Strobes, one cycle after the write
    logic [LANES-1:0]  lane_hot;          // Decoded lane select

    // Input side
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            shift_q <= '0;
        end else begin
            shift_q <= {shift_q[BUS_W-2:0], serial_in};   // Older bits move up
        end
    end

    // Lane k lives in bits 8k+7 down to 8k
    assign bus.rdata = shift_q[bus.lane*WORD_W +: WORD_W];

    // Lane decode
    always_comb begin
        lane_hot = '0;
        lane_hot[bus.lane] = 1'b1;
    end

    // Output lanes, written at the acceptance edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < LANES; k++) begin
                out_q[k] <= '0;
            end
        end else if (bus.we) begin
            out_q[bus.lane] <= bus.wdata;
        end
    end

    // Strobe follows the write by one cycle and lasts one cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wren_q <= '0;
        end else if (bus.we) begin
            wren_q <= lane_hot;                           // Only the written lane
        end else begin
            wren_q <= '0;
        end
    end

    // Old value of the addressed lane, used as the write response
    assign bus.odata = out_q[bus.lane];

    // Flatten lanes for the pin reducers and LED tap
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            bus.out_bus[k*WORD_W +: WORD_W] = out_q[k];
        end
    end

    assign bus.wren_bus = wren_q;

endmodule

// File: sources.f
+incdir+common
common/io_harness_pkg.sv
common/io_port_if.sv
port_bank/io_port_bank.sv
hdl/io_cmd_router.sv
hdl/board_io_harness.sv
test/board_io_harness_assert.sv
test/board_io_harness_tb.sv

// File: test/board_io_harness_assert.sv
`include "io_harness_cfg.svh"

module board_io_harness_assert (
    input logic                 clock,
    input logic                 arst_n,
    input logic                 cmd_ready,
    input logic                 rsp_valid,
    input logic                 rsp_ready,
    input logic [7:0]           rsp_data,
    input logic [`IO_LANES-1:0] a_wren_bus,     // Bank A strobes, tapped inside the top
    input logic [`IO_LANES-1:0] b_wren_bus      // Bank B strobes
);

    int unsigned fail_count = 0;                // Failed assertions so far

    // Stalled response must hold its value
    rsp_hold: assert property (@(posedge clock) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
        else begin
            $error("response dropped or changed under stall");
            fail_count++;
        end

    // Full buffer blocks new commands, no write reaches a bank
    ready_low: assert property (@(posedge clock) disable iff (!arst_n)
        rsp_valid && !rsp_ready |-> !cmd_ready ##1 ((a_wren_bus == '0) && (b_wren_bus == '0)))
        else begin
            $error("command taken while response waits");
            fail_count++;
        end

    // At most one lane strobed per bank
    strobe_onehot: assert property (@(posedge clock) disable iff (!arst_n)
        $onehot0(a_wren_bus) && $onehot0(b_wren_bus))
        else begin
            $error("wren_bus not zero or one-hot");
            fail_count++;
        end

    // Strobes last one cycle only
    strobe_single: assert property (@(posedge clock) disable iff (!arst_n)
        ((a_wren_bus & $past(a_wren_bus)) == '0) && ((b_wren_bus & $past(b_wren_bus)) == '0))
        else begin
            $error("strobe bit high two cycles in a row");
            fail_count++;
        end

endmodule

// File: test/board_io_harness_tb.sv
`include "io_harness_cfg.svh"

module board_io_harness_tb;

    import io_harness_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;                 // Inputs change after the rising edge
    localparam int RESET_CYCLES = 5;
    localparam int LANES        = `IO_LANES;
    localparam int BUS_W        = `IO_BUS_W;
    localparam int N_TESTS      = 19;
    localparam int SEED         = 47875;
    localparam int LIMIT_CYCLES = N_TESTS * 20 + RESET_CYCLES + BUS_W + 2;

    typedef struct {
        io_cmd_t    cmd;
        logic [7:0] dip;
        logic [1:0] btn;
        int         stall;                            // Cycles rsp_ready stays low
        logic [7:0] expected;                         // Filled from the model at acceptance
    } test_entry_t;

    logic       clock, arst_n, cmd_valid, rsp_ready, a_serial_in, b_serial_in;
    io_cmd_t    cmd_word;
    logic [7:0] dip_switch;
    logic [1:0] push_button;
    logic       cmd_ready, rsp_valid, a_wren_pin, a_out_pin, b_wren_pin, b_out_pin;
    logic [7:0] rsp_data, led;

    test_entry_t       tests [N_TESTS];
    int                n_filled    = 0;
    int                error_count = 0;
    int                failed      = 0;
    logic [BUS_W-1:0]  a_pattern, b_pattern;          // Random serial preload
    logic [BUS_W-1:0]  sr_a_model, sr_b_model;        // Last 32 bits seen on each pin
    logic [7:0]        out_a_model [LANES];
    logic [7:0]        out_b_model [LANES];
    logic [7:0]        led_model = '0;
    int unsigned       a_wren_seen = 0;
    int unsigned       b_wren_seen = 0;

    board_io_harness board_io_harness_i (.*);

    bind board_io_harness board_io_harness_assert assert_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .cmd_ready  (cmd_ready),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .a_wren_bus (port_a_if.wren_bus),
        .b_wren_bus (port_b_if.wren_bus)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Serial pins replay the preload pattern, MSB first
    initial begin
        int idx;
        idx = 0;
        wait (arst_n);
        forever begin
            @(posedge clock);
            #(DRIVE_DELAY);
            a_serial_in = a_pattern[BUS_W-1-idx];
            b_serial_in = b_pattern[BUS_W-1-idx];
            idx = (idx + 1) % BUS_W;
        end
    end

    // Shift model, newest bit at 0
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sr_a_model <= '0;
            sr_b_model <= '0;
        end else begin
            sr_a_model <= {sr_a_model[BUS_W-2:0], a_serial_in};
            sr_b_model <= {sr_b_model[BUS_W-2:0], b_serial_in};
        end
    end

    always @(negedge clock) begin
        if (a_wren_pin) a_wren_seen++;                // Cycles with the pin high
        if (b_wren_pin) b_wren_seen++;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    function automatic io_cmd_t make_rd(input logic port, input int lane, input logic invert,
                                        input logic [7:0] mask);
        io_cmd_t c;
        c           = '0;
        c.rd.op     = `IO_OP_RD;
        c.rd.port   = port;
        c.rd.lane   = lane_idx_t'(lane);
        c.rd.invert = invert;
        c.rd.mask   = mask;
        return c;
    endfunction

    function automatic io_cmd_t make_wr(input logic port, input int lane, input logic [7:0] data);
        io_cmd_t c;
        c          = '0;
        c.wr.op    = `IO_OP_WR;
        c.wr.port  = port;
        c.wr.lane  = lane_idx_t'(lane);
        c.wr.wdata = data;
        return c;
    endfunction

    task automatic add_entry(input io_cmd_t cmd, input logic [7:0] dip, input logic [1:0] btn,
                             input int stall);
        tests[n_filled] = '{cmd, dip, btn, stall, 8'h00};
        n_filled++;
    endtask

    // Response rule, taken at the acceptance edge
    function automatic logic [7:0] expected_response(input io_cmd_t c, input logic [7:0] dip,
                                                     input logic [1:0] btn);
        logic [7:0] word;
        int         lane;
        lane = int'(c.rd.lane);
        if (c.wr.op) return c.wr.port ? out_b_model[lane] : out_a_model[lane];
        word = c.rd.port ? sr_b_model[lane*8 +: 8] : sr_a_model[lane*8 +: 8];
        if (!c.rd.port && lane == 0) word = dip;      // Switch overlay
        if (!c.rd.port && lane == 1) word[1:0] = btn; // Buttons in the low bits
        word = word & c.rd.mask;
        return c.rd.invert ? ~word : word;
    endfunction

    task automatic update_output_model(input io_cmd_t c);
        int lane;
        lane = int'(c.wr.lane);
        if (c.wr.op && c.wr.port) begin
            out_b_model[lane] = c.wr.wdata;
            if (lane == 0) led_model = c.wr.wdata;    // LEDs mirror B lane 0
        end else if (c.wr.op) begin
            out_a_model[lane] = c.wr.wdata;
        end
    endtask

    function automatic logic bank_parity(input logic port);
        logic p;
        p = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            p = p ^ (^(port ? out_b_model[k] : out_a_model[k]));
        end
        return p;
    endfunction

    task automatic run_entry(input int idx);
        io_cmd_t     c;
        logic [7:0]  held;
        int          errs_before;
        int unsigned a_before, b_before;
        c           = tests[idx].cmd;
        errs_before = error_count;
        a_before    = a_wren_seen;
        b_before    = b_wren_seen;
        @(posedge clock);
        #(DRIVE_DELAY);
        cmd_word    = c;
        cmd_valid   = 1'b1;
        dip_switch  = tests[idx].dip;
        push_button = tests[idx].btn;
        @(negedge clock);
        while (!cmd_ready) @(negedge clock);          // Next rising edge accepts
        tests[idx].expected = expected_response(c, tests[idx].dip, tests[idx].btn);
        update_output_model(c);
        @(posedge clock);
        #(DRIVE_DELAY);
        cmd_valid = 1'b0;
        @(negedge clock);
        while (!rsp_valid) @(negedge clock);
        held = rsp_data;
        check_value("rsp_data", held, tests[idx].expected);
        check_value("cmd_ready", cmd_ready, 1'b0);    // Buffer full, ready low
        repeat (tests[idx].stall) begin
            @(posedge clock);
            #(DRIVE_DELAY);
            if (idx + 1 < N_TESTS) begin
                cmd_word  = tests[idx + 1].cmd;       // Next command waits behind the stall
                cmd_valid = 1'b1;
            end
            @(negedge clock);
            check_value("rsp_valid", rsp_valid, 1'b1);
            check_value("rsp_data", rsp_data, held);
            check_value("cmd_ready", cmd_ready, 1'b0);
        end
        @(posedge clock);
        #(DRIVE_DELAY);
        cmd_valid = 1'b0;                             // Offered again by its own entry
        rsp_ready = 1'b1;
        @(posedge clock);
        #(DRIVE_DELAY);
        rsp_ready = 1'b0;
        check_value("led", led, led_model);
        check_value("a_out_pin", a_out_pin, bank_parity(1'b0));
        check_value("b_out_pin", b_out_pin, bank_parity(1'b1));
        check_value("a_wren_pin count", a_wren_seen - a_before, c.wr.op && !c.wr.port);
        check_value("b_wren_pin count", b_wren_seen - b_before, c.wr.op && c.wr.port);
        if (error_count != errs_before) failed++;
        $display("test %2d  cmd %h  rsp %h  %s", idx, c, held,
                 (error_count == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        arst_n      = 1'b0;
        cmd_valid   = 1'b0;
        cmd_word    = '0;
        rsp_ready   = 1'b0;
        dip_switch  = '0;
        push_button = '0;
        a_serial_in = 1'b0;
        b_serial_in = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            out_a_model[k] = '0;
            out_b_model[k] = '0;
        end
        void'($urandom(SEED));
        a_pattern = $urandom();
        b_pattern = $urandom();
        add_entry(make_rd(1'b1, 0, 1'b0, 8'hff), 8'h00, 2'b00, 0);   // B lanes, plain
        add_entry(make_rd(1'b1, 1, 1'b0, 8'hff), 8'h00, 2'b00, 0);
        add_entry(make_rd(1'b1, 2, 1'b0, 8'hff), 8'h00, 2'b00, 0);
        add_entry(make_rd(1'b1, 3, 1'b0, 8'hff), 8'h00, 2'b00, 3);
        add_entry(make_rd(1'b1, 2, 1'b1, 8'h3c), 8'h00, 2'b00, 0);   // Mask and invert
        add_entry(make_rd(1'b0, 0, 1'b0, 8'hff), 8'h5a, 2'b00, 0);   // Switches
        add_entry(make_rd(1'b0, 0, 1'b0, 8'hff), 8'ha5, 2'b11, 0);
        add_entry(make_rd(1'b0, 1, 1'b0, 8'hff), 8'h00, 2'b10, 0);   // Buttons
        add_entry(make_rd(1'b0, 1, 1'b0, 8'hff), 8'h00, 2'b01, 4);
        add_entry(make_wr(1'b0, 2, 8'h3c), 8'h00, 2'b00, 0);
        add_entry(make_wr(1'b0, 2, 8'h99), 8'h00, 2'b00, 0);         // Returns 3c
        add_entry(make_wr(1'b1, 0, 8'ha7), 8'h00, 2'b00, 0);         // LED load
        add_entry(make_wr(1'b1, 1, 8'h42), 8'h00, 2'b00, 0);         // LED unchanged
        add_entry(make_wr(1'b1, 0, 8'h18), 8'h00, 2'b00, 5);
        add_entry(make_wr(1'b0, 0, 8'hf1), 8'h00, 2'b00, 0);         // Odd parity on A
        add_entry(make_rd(1'b0, 3, 1'b1, 8'h0f), 8'h00, 2'b00, 0);
        add_entry(make_wr(1'b1, 3, 8'h81), 8'h00, 2'b00, 2);
        add_entry(make_rd(1'b1, 0, 1'b0, 8'hff), 8'h00, 2'b00, 0);   // Right after a stall
        add_entry(make_wr(1'b0, 1, 8'h11), 8'h00, 2'b00, 0);
        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        arst_n = 1'b1;
        repeat (BUS_W + 1) @(posedge clock);          // Full preload shifted in
        for (int i = 0; i < N_TESTS; i++) begin
            run_entry(i);
        end
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 N_TESTS, N_TESTS - failed, failed, error_count,
                 board_io_harness_i.assert_i.fail_count);
        if (error_count == 0 && board_io_harness_i.assert_i.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
